//--- logic/bus_pkg.sv
// ----------------------------------------
// Wishbone register map of the peripheral slice
// Word addresses on a 2-bit adr, 32-bit data
// Address 3 is unmapped and acknowledged harmlessly
// ----------------------------------------
`default_nettype none

package bus_pkg;

    localparam int BUS_DATA_W = 32;

    localparam logic [1:0] ADDR_LED   = 2'd0;
    localparam logic [1:0] ADDR_AUDIO = 2'd1;
    localparam logic [1:0] ADDR_PAD   = 2'd2;

    // One decoded bus request, held for a single cycle
    typedef enum logic [2:0] {
        OP_NONE,
        OP_WR_LED,
        OP_WR_AUDIO,
        OP_RD_LED,
        OP_RD_AUDIO,
        OP_RD_PAD,
        OP_UNMAPPED
    } reg_op_e;

endpackage

`default_nettype wire

//--- logic/periph_pkg.sv
// ----------------------------------------
// Widths of the audio, DAC, LED and pad paths
// The DAC accumulator width is PCM_W - DAC_W
// ----------------------------------------
`default_nettype none

package periph_pkg;

    // 16-bit PCM per channel, two channels per audio word
    localparam int PCM_W = 16;

    // Pin DAC resolution per channel
    localparam int DAC_W = 4;

    // Serial pad with 12 buttons
    localparam int PAD_BTN_W = 12;

    localparam int LED_W = 8;

    // Pad scan phases
    typedef enum logic [1:0] {
        SCAN_LATCH,
        SCAN_LOW,
        SCAN_HIGH
    } scan_state_e;

endpackage

`default_nettype wire

//--- logic/pcm_dac.sv
// ----------------------------------------
// First-order delta-sigma, 16-bit PCM to 4-bit pin
// Unsigned samples, output saturates at 15
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ps

module pcm_dac (
    input  wire logic                      clk_2x,
    input  wire logic                      arst_n,
    input  wire logic [periph_pkg::PCM_W-1:0] pcm,
    output logic [periph_pkg::DAC_W-1:0]   dac
);
    import periph_pkg::*;

    localparam int FRAC_W = PCM_W - DAC_W;

    logic [FRAC_W-1:0] acc;
    logic [FRAC_W:0]   acc_sum;
    logic [DAC_W:0]    level;

    // Carry out of the fraction adds one LSB to the top nibble
    assign acc_sum = {1'b0, acc} + {1'b0, pcm[FRAC_W-1:0]};
    assign level   = {1'b0, pcm[PCM_W-1:FRAC_W]} + {{DAC_W{1'b0}}, acc_sum[FRAC_W]};

    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
            dac <= '0;
        end else begin
            acc <= acc_sum[FRAC_W-1:0];
            dac <= level[DAC_W] ? {DAC_W{1'b1}} : level[DAC_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- logic/pad_scanner.sv
// ----------------------------------------
// Serial pad scanner, 25 half-periods per scan
// PAD_CLK_DIV clk_2x cycles per half-period, >= 2
// pad_data is active low, sampled at end of low phase
// pad_btn only changes once a full word is in
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ps

module pad_scanner #(
    parameter int PAD_CLK_DIV = 4
) (
    input  wire logic                          clk_2x,
    input  wire logic                          arst_n,
    input  wire logic                          pad_data,
    output logic                               pad_latch,
    output logic                               pad_clk,
    output logic [periph_pkg::PAD_BTN_W-1:0]   pad_btn
);
    import periph_pkg::*;

    localparam int DIV_W = $clog2(PAD_CLK_DIV);
    localparam int BIT_W = $clog2(PAD_BTN_W);

    scan_state_e          state_q;
    scan_state_e          state_d;
    logic [DIV_W-1:0]     div_cnt;
    logic [BIT_W-1:0]     bit_cnt;
    logic [PAD_BTN_W-1:0] shreg;
    logic                 half_end;
    logic                 last_bit;

    assign half_end = (div_cnt == DIV_W'(PAD_CLK_DIV - 1));
    assign last_bit = (bit_cnt == BIT_W'(PAD_BTN_W - 1));

    always_comb begin
        state_d = state_q;
        if (half_end) begin
            case (state_q)
                SCAN_LATCH: state_d = SCAN_LOW;
                SCAN_LOW:   state_d = SCAN_HIGH;
                SCAN_HIGH:  state_d = last_bit ? SCAN_LATCH : SCAN_LOW;
                default:    state_d = SCAN_LATCH;
            endcase
        end
    end

    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= SCAN_LATCH;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            pad_latch <= 1'b0;
            pad_clk   <= 1'b0;
            pad_btn   <= '0;
        end else begin
            state_q   <= state_d;
            div_cnt   <= half_end ? '0 : div_cnt + 1'b1;
            // Pins follow the state register without a cycle of lag
            pad_latch <= (state_d == SCAN_LATCH);
            pad_clk   <= (state_d == SCAN_HIGH);
            if (half_end && state_q == SCAN_LATCH) begin
                bit_cnt <= '0;
            end
            if (half_end && state_q == SCAN_HIGH) begin
                if (last_bit) begin
                    pad_btn <= shreg;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // Button 0 arrives first and ends up in bit 0
    always_ff @(posedge clk_2x) begin
        if (half_end && state_q == SCAN_LOW) begin
            shreg <= {~pad_data, shreg[PAD_BTN_W-1:1]};
        end
    end

endmodule

`default_nettype wire

//--- logic/bus_decode.sv
// ----------------------------------------
// Takes one request per Wishbone cycle
// op is valid for exactly one clock
// The master must drop stb after seeing ack
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ps

module bus_decode (
    input  wire logic                          clk_2x,
    input  wire logic                          arst_n,
    input  wire logic                          cyc,
    input  wire logic                          stb,
    input  wire logic                          we,
    input  wire logic [1:0]                    adr,
    input  wire logic [bus_pkg::BUS_DATA_W-1:0] dat_w,
    input  wire logic                          ack,
    output bus_pkg::reg_op_e                   op,
    output logic [bus_pkg::BUS_DATA_W-1:0]     wdata
);
    import bus_pkg::*;

    reg_op_e op_d;
    logic    take;

    // No new request while the previous one is still in flight
    assign take = cyc && stb && !ack && (op == OP_NONE);

    always_comb begin
        case (adr)
            ADDR_LED:   op_d = we ? OP_WR_LED : OP_RD_LED;
            ADDR_AUDIO: op_d = we ? OP_WR_AUDIO : OP_RD_AUDIO;
            // Pad word is read-only
            ADDR_PAD:   op_d = we ? OP_UNMAPPED : OP_RD_PAD;
            default:    op_d = OP_UNMAPPED;
        endcase
    end

    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            op <= OP_NONE;
        end else begin
            op <= take ? op_d : OP_NONE;
        end
    end

    always_ff @(posedge clk_2x) begin
        if (take) begin
            wdata <= dat_w;
        end
    end

endmodule

`default_nettype wire

//--- logic/bus_result.sv
// ----------------------------------------
// Registered read data and acknowledge
// One ack per decoded opcode, dat_r valid with ack
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ps

module bus_result (
    input  wire logic                               clk_2x,
    input  wire logic                               arst_n,
    input  var  bus_pkg::reg_op_e                   op,
    input  wire logic [periph_pkg::LED_W-1:0]       led_q,
    input  wire logic [2*periph_pkg::PCM_W-1:0]     audio_q,
    input  wire logic [periph_pkg::PAD_BTN_W-1:0]   pad_q,
    output logic [bus_pkg::BUS_DATA_W-1:0]          dat_r,
    output logic                                    ack
);
    import bus_pkg::*;

    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= (op != OP_NONE);
        end
    end

    // Writes and unmapped reads return zero
    always_ff @(posedge clk_2x) begin
        case (op)
            OP_RD_LED:   dat_r <= BUS_DATA_W'(led_q);
            OP_RD_AUDIO: dat_r <= BUS_DATA_W'(audio_q);
            OP_RD_PAD:   dat_r <= BUS_DATA_W'(pad_q);
            default:     dat_r <= '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/periph_execute.sv
// ----------------------------------------
// LED and stereo sample registers plus the
// pad scanner and both pin DACs
// Writes take effect on the edge after decode
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ps

module periph_execute #(
    parameter int PAD_CLK_DIV = 4
) (
    input  wire logic                               clk_2x,
    input  wire logic                               arst_n,
    input  var  bus_pkg::reg_op_e                   op,
    input  wire logic [bus_pkg::BUS_DATA_W-1:0]     wdata,
    input  wire logic                               pad_data,
    output logic [periph_pkg::LED_W-1:0]            led_q,
    output logic [2*periph_pkg::PCM_W-1:0]          audio_q,
    output logic [periph_pkg::PAD_BTN_W-1:0]        pad_q,
    output logic [periph_pkg::DAC_W-1:0]            audio_l,
    output logic [periph_pkg::DAC_W-1:0]            audio_r,
    output logic                                    audio_valid,
    output logic                                    pad_latch,
    output logic                                    pad_clk
);
    import bus_pkg::*;
    import periph_pkg::*;

    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            led_q       <= '0;
            audio_q     <= '0;
            audio_valid <= 1'b0;
        end else begin
            audio_valid <= (op == OP_WR_AUDIO);
            if (op == OP_WR_LED) begin
                led_q <= wdata[LED_W-1:0];
            end
            // Left sample in the upper half, right in the lower
            if (op == OP_WR_AUDIO) begin
                audio_q <= wdata[2*PCM_W-1:0];
            end
        end
    end

    pad_scanner #(
        .PAD_CLK_DIV(PAD_CLK_DIV)
    ) u_scanner (
        .clk_2x    (clk_2x),
        .arst_n    (arst_n),
        .pad_data  (pad_data),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .pad_btn   (pad_q)
    );

    pcm_dac u_dac_l (
        .clk_2x (clk_2x),
        .arst_n (arst_n),
        .pcm    (audio_q[2*PCM_W-1:PCM_W]),
        .dac    (audio_l)
    );

    pcm_dac u_dac_r (
        .clk_2x (clk_2x),
        .arst_n (arst_n),
        .pcm    (audio_q[PCM_W-1:0]),
        .dac    (audio_r)
    );

endmodule

`default_nettype wire

//--- logic/periph_top.sv
// ----------------------------------------
// Peripheral slice as a Wishbone classic slave
// Fixed ack latency of two edges after stb
// No err or rty, unmapped accesses are acked
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ps

module periph_top #(
    parameter int PAD_CLK_DIV = 4
) (
    input  wire logic                               clk_2x,
    input  wire logic                               arst_n,
    input  wire logic                               cyc,
    input  wire logic                               stb,
    input  wire logic                               we,
    input  wire logic [1:0]                         adr,
    input  wire logic [bus_pkg::BUS_DATA_W-1:0]     dat_w,
    output logic [bus_pkg::BUS_DATA_W-1:0]          dat_r,
    output logic                                    ack,
    output logic [periph_pkg::LED_W-1:0]            led,
    output logic [periph_pkg::DAC_W-1:0]            audio_l,
    output logic [periph_pkg::DAC_W-1:0]            audio_r,
    output logic                                    audio_valid,
    input  wire logic                               pad_data,
    output logic                                    pad_latch,
    output logic                                    pad_clk
);
    import bus_pkg::*;
    import periph_pkg::*;

    reg_op_e                op;
    logic [BUS_DATA_W-1:0]  wdata;
    logic [2*PCM_W-1:0]     audio_q;
    logic [PAD_BTN_W-1:0]   pad_q;

    bus_decode u_decode (
        .clk_2x (clk_2x),
        .arst_n (arst_n),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_w  (dat_w),
        .ack    (ack),
        .op     (op),
        .wdata  (wdata)
    );

    // LED register drives the pins directly
    periph_execute #(
        .PAD_CLK_DIV(PAD_CLK_DIV)
    ) u_execute (
        .clk_2x      (clk_2x),
        .arst_n      (arst_n),
        .op          (op),
        .wdata       (wdata),
        .pad_data    (pad_data),
        .led_q       (led),
        .audio_q     (audio_q),
        .pad_q       (pad_q),
        .audio_l     (audio_l),
        .audio_r     (audio_r),
        .audio_valid (audio_valid),
        .pad_latch   (pad_latch),
        .pad_clk     (pad_clk)
    );

    bus_result u_result (
        .clk_2x  (clk_2x),
        .arst_n  (arst_n),
        .op      (op),
        .led_q   (led),
        .audio_q (audio_q),
        .pad_q   (pad_q),
        .dat_r   (dat_r),
        .ack     (ack)
    );

endmodule

`default_nettype wire

//--- bench/periph_chk.sv
// ----------------------------------------
// Wishbone and pad pin protocol checks
// Bound into periph_top; fail_cnt counts failures
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ps

module periph_chk (
    input  wire logic             clk_2x,
    input  wire logic             arst_n,
    input  wire logic             cyc,
    input  wire logic             stb,
    input  wire logic             ack,
    input  wire logic             pad_latch,
    input  wire logic             pad_clk
);

    int unsigned fail_cnt = 0;

    // ack only inside an active bus cycle
    ack_in_cycle: assert property (@(posedge clk_2x) disable iff (!arst_n)
        ack |-> (cyc && stb))
        else begin
            $error("ack high without cyc and stb");
            fail_cnt++;
        end

    ack_single: assert property (@(posedge clk_2x) disable iff (!arst_n)
        ack |=> !ack)
        else begin
            $error("ack held high for two cycles");
            fail_cnt++;
        end

    // Fixed latency of two edges from the first sampled stb
    ack_latency: assert property (@(posedge clk_2x) disable iff (!arst_n)
        $rose(cyc && stb) |-> !ack ##1 !ack ##1 ack)
        else begin
            $error("ack did not follow the request by two edges");
            fail_cnt++;
        end

    pad_pins: assert property (@(posedge clk_2x) disable iff (!arst_n)
        !(pad_latch && pad_clk))
        else begin
            $error("pad latch and pad clock high together");
            fail_cnt++;
        end

endmodule

bind periph_top periph_chk u_chk (
    .clk_2x    (clk_2x),
    .arst_n    (arst_n),
    .cyc       (cyc),
    .stb       (stb),
    .ack       (ack),
    .pad_latch (pad_latch),
    .pad_clk   (pad_clk)
);

`default_nettype wire

//--- bench/periph_tb.sv
// ----------------------------------------
// Testbench for periph_top acting as CPU and pad
// Pad divider fixed at 4, seeded $urandom stimulus
// Value checks are immediate assertions here
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ps

module periph_tb;
    import bus_pkg::*;

    localparam int PAD_DIV     = 4;
    localparam int SCAN_CYC    = 25 * PAD_DIV;
    localparam int PAD_CHECKS  = 6;
    localparam int DAC_WINDOW  = 4096;
    localparam int ACK_LIMIT   = 16;
    localparam int CYCLE_LIMIT = 3000 + PAD_CHECKS * 2 * SCAN_CYC + 2 * 4100;

    logic        clk_2x = 1'b0;
    logic        arst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] dat_w;
    logic        pad_data;
    logic [31:0] dat_r;
    logic        ack;
    logic [7:0]  led;
    logic [3:0]  audio_l;
    logic [3:0]  audio_r;
    logic        audio_valid;
    logic        pad_latch;
    logic        pad_clk;

    // Pad model state
    logic [11:0] pad_word = '0;
    logic [11:0] pad_shift = '0;
    logic        latch_d = 1'b0;
    logic        pclk_d = 1'b0;

    int          err_cnt = 0;
    int unsigned valid_cnt = 0;
    int          cycles = 0;

    always #5 clk_2x = ~clk_2x;

    periph_top #(
        .PAD_CLK_DIV(PAD_DIV)
    ) u_dut (
        .clk_2x      (clk_2x),
        .arst_n      (arst_n),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_w       (dat_w),
        .dat_r       (dat_r),
        .ack         (ack),
        .led         (led),
        .audio_l     (audio_l),
        .audio_r     (audio_r),
        .audio_valid (audio_valid),
        .pad_data    (pad_data),
        .pad_latch   (pad_latch),
        .pad_clk     (pad_clk)
    );

    // Serial pad, reloads on latch, button pressed drives data low
    always @(posedge clk_2x) begin
        latch_d <= pad_latch;
        pclk_d  <= pad_clk;
        if (pad_latch && !latch_d) begin
            pad_shift <= pad_word;
            pad_data  <= ~pad_word[0];
        end else if (pad_clk && !pclk_d) begin
            pad_shift <= pad_shift >> 1;
            pad_data  <= ~pad_shift[1];
        end
    end

    always @(posedge clk_2x) begin
        if (audio_valid) begin
            valid_cnt <= valid_cnt + 1;
        end
    end

    always @(posedge clk_2x) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    // One classic cycle, returns read data sampled with ack
    task automatic bus_access(input logic wr, input logic [1:0] a,
                              input logic [31:0] wd, output logic [31:0] rd);
        int waited;
        @(posedge clk_2x);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        adr   <= a;
        dat_w <= wd;
        @(posedge clk_2x);
        waited = 1;
        while (!ack && waited < ACK_LIMIT) begin
            @(posedge clk_2x);
            waited++;
        end
        if (!ack) begin
            $display("No ack for the access to address %0d", a);
            err_cnt++;
        end
        rd = dat_r;
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic write_reg(input logic [1:0] a, input logic [31:0] d);
        logic [31:0] discard;
        bus_access(1'b1, a, d, discard);
    endtask

    task automatic read_reg(input logic [1:0] a, output logic [31:0] d);
        bus_access(1'b0, a, 32'h0, d);
    endtask

    task automatic check_quiet();
        expect_eq("ack", ack, 0);
        expect_eq("led", led, 0);
        expect_eq("audio_l", audio_l, 0);
        expect_eq("audio_r", audio_r, 0);
        expect_eq("audio_valid", audio_valid, 0);
        expect_eq("pad_latch", pad_latch, 0);
        expect_eq("pad_clk", pad_clk, 0);
    endtask

    // A steady sample sums to itself over 4096 DAC cycles
    task automatic check_audio(input logic [15:0] left, input logic [15:0] right);
        logic [31:0] rd;
        int unsigned pulses;
        int unsigned sum_l;
        int unsigned sum_r;
        pulses = valid_cnt;
        sum_l = 0;
        sum_r = 0;
        write_reg(ADDR_AUDIO, {left, right});
        repeat (4) @(posedge clk_2x);
        repeat (DAC_WINDOW) begin
            @(posedge clk_2x);
            sum_l += audio_l;
            sum_r += audio_r;
        end
        expect_eq("audio_l sum", sum_l, {16'h0, left});
        expect_eq("audio_r sum", sum_r, {16'h0, right});
        expect_eq("audio_valid pulses", valid_cnt - pulses, 1);
        read_reg(ADDR_AUDIO, rd);
        expect_eq("dat_r", rd, {left, right});
    endtask

    task automatic check_pad(input logic [11:0] w);
        logic [31:0] rd;
        @(posedge clk_2x);
        pad_word <= w;
        repeat (2 * SCAN_CYC + 4) @(posedge clk_2x);
        read_reg(ADDR_PAD, rd);
        expect_eq("dat_r", rd, {20'h0, w});
    endtask

    initial begin : main
        logic [31:0] rd;
        logic [31:0] v;
        logic [15:0] left;
        logic [15:0] right;
        logic [11:0] w;
        void'($urandom(32'h8f7f90b6));
        arst_n   = 1'b0;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = 2'd0;
        dat_w    = 32'h0;
        pad_data = 1'b1;

        @(posedge clk_2x);
        repeat (2) begin
            @(posedge clk_2x);
            check_quiet();
        end
        arst_n <= 1'b1;
        @(posedge clk_2x);
        check_quiet();

        for (int i = 0; i < 4; i++) begin
            v = $urandom;
            write_reg(ADDR_LED, v);
            expect_eq("led", led, {24'h0, v[7:0]});
            read_reg(ADDR_LED, rd);
            expect_eq("dat_r", rd, {24'h0, v[7:0]});
        end

        // Top nibble kept below 15 so the DAC never saturates
        for (int i = 0; i < 2; i++) begin
            left  = {4'($urandom % 15), 12'($urandom)};
            right = {4'($urandom % 15), 12'($urandom)};
            check_audio(left, right);
        end

        // Unmapped and pad writes keep the last LED and audio values
        read_reg(2'd3, rd);
        expect_eq("dat_r", rd, 0);
        write_reg(2'd3, $urandom);
        write_reg(ADDR_PAD, $urandom);
        expect_eq("led", led, {24'h0, v[7:0]});
        read_reg(ADDR_LED, rd);
        expect_eq("dat_r", rd, {24'h0, v[7:0]});
        read_reg(ADDR_AUDIO, rd);
        expect_eq("dat_r", rd, {left, right});

        for (int i = 0; i < PAD_CHECKS; i++) begin
            if (i == 0) begin
                w = 12'hfff;
            end else if (i == 1) begin
                w = 12'h000;
            end else begin
                w = 12'($urandom);
            end
            check_pad(w);
        end

        $display("Errors: %0d value, %0d protocol", err_cnt, u_dut.u_chk.fail_cnt);
        if (err_cnt == 0 && u_dut.u_chk.fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
logic/bus_pkg.sv
logic/periph_pkg.sv
logic/pcm_dac.sv
logic/pad_scanner.sv
logic/bus_decode.sv
logic/bus_result.sv
logic/periph_execute.sv
logic/periph_top.sv
bench/periph_chk.sv
bench/periph_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile periph_tb with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module periph_tb \
    -f vlog.f -o periph_sim || { echo "Verilator build failed"; exit 1; }

./obj_dir/periph_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q ">>> FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
